/* obj_engine_asserts.sv */
`timescale 1ns/1ns
/* handshake checks inside obj_engine_top
   table read, scanner to drawer and drawer pixel run */
module obj_engine_asserts (
    input logic clk,
    input logic rst,
    input logic draw_req,
    input logic draw_idle,
    input logic rd_req,
    input logic rd_valid,
    input logic buf_we,
    input logic rom_cs
);
    logic       rd_wait;                    // read out, answer not seen yet
    logic [4:0] quiet;                      // pixel cycles left after rom_cs
    int         fail_count = 0;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rd_wait <= 1'b0;
            quiet   <= '0;
        end else begin
            rd_wait <= (rd_req || rd_wait) && !rd_valid;
            if (rom_cs)
                quiet <= 5'd16;
            else if (quiet != 5'd0)
                quiet <= quiet - 5'd1;
        end
    end

    a_req_idle: assert property (@(posedge clk) disable iff (rst) draw_req |-> draw_idle)
        else begin
            fail_count++;
            $error("draw_req while drawer busy");
        end

    a_one_read: assert property (@(posedge clk) disable iff (rst) rd_req |-> !rd_wait)
        else begin
            fail_count++;
            $error("rd_req before rd_valid of previous read");
        end

    // pixels only in the 16 cycles that follow a rom fetch
    a_we_run: assert property (@(posedge clk) disable iff (rst) buf_we |-> (quiet != 5'd0))
        else begin
            fail_count++;
            $error("buf_we outside the pixel run of a fetched row");
        end

    a_pix_run: assert property (@(posedge clk) disable iff (rst) (quiet != 5'd0) |-> !draw_req)
        else begin
            fail_count++;
            $error("draw_req during pixel run");
        end

endmodule

bind obj_engine_top obj_engine_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .draw_req  (draw_req),
    .draw_idle (draw_idle),
    .rd_req    (rd_req),
    .rd_valid  (rd_valid),
    .buf_we    (buf_we),
    .rom_cs    (rom_cs)
);

/* obj_engine_top.sv */
`timescale 1ns/1ns
/* object line engine: table, scanner, drawer, line buffer
   raster timing comes from outside; line_start is a one cycle strobe
   graphics rom is external with one cycle read latency */
module obj_engine_top import obj_pkg::*; #(
    parameter int OBJ_AW = obj_pkg::OBJ_AW
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flip,
    input  logic              line_start,
    input  logic [8:0]        vrender,
    input  logic              host_we,
    input  logic [OBJ_AW-1:0] host_addr,
    input  obj_entry_t        host_entry,
    output logic              rom_cs,
    output logic [19:0]       rom_addr,
    input  logic [63:0]       rom_data,
    input  logic [8:0]        video_hpos,
    output obj_pix_t          video_pix,
    output logic              scan_busy
);
    logic              rd_req;
    logic [OBJ_AW-1:0] rd_addr;
    obj_entry_t        rd_entry;
    logic              rd_valid;
    logic              draw_req;
    obj_draw_t         draw_job;
    logic              draw_idle;
    logic              buf_we;
    logic [8:0]        buf_addr;
    obj_pix_t          buf_pix;

    obj_table_mem #(.OBJ_AW(OBJ_AW)) u_table (
        .clk, .rst, .host_we, .host_addr, .host_entry,
        .rd_req, .rd_addr, .rd_entry, .rd_valid
    );

    obj_line_scan #(.OBJ_AW(OBJ_AW)) u_scan (
        .clk, .rst, .flip, .line_start, .vrender,
        .rd_req, .rd_addr, .rd_entry, .rd_valid,
        .draw_req, .draw_job, .draw_idle, .scan_busy
    );

    obj_line_draw u_draw (
        .clk, .rst, .draw_req, .draw_job, .draw_idle,
        .rom_cs, .rom_addr, .rom_data,
        .buf_we, .buf_addr, .buf_pix
    );

    obj_line_buf u_buf (
        .clk, .rst, .line_start,
        .buf_we, .buf_addr, .buf_pix,
        .video_hpos, .video_pix
    );

endmodule

/* obj_line_buf.sv */
`timescale 1ns/1ns
/* double line buffer, 512 pixels per bank
   first write to a location wins until the video side reads it
   video reads clear the location, so each pixel reads once */
module obj_line_buf import obj_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       line_start,
    input  logic       buf_we,
    input  logic [8:0] buf_addr,
    input  obj_pix_t   buf_pix,
    input  logic [8:0] video_hpos,
    output obj_pix_t   video_pix
);
    obj_pix_t         pix [2][512];         // pixel data, valid only where occupied
    logic [1:0][511:0] occ;                 // occupied flags per bank
    logic             bank;                 // draw bank, video reads the other
    logic             vbank;
    logic             wr_ok;

    assign vbank = ~bank;
    assign wr_ok = buf_we && !occ[bank][buf_addr];   // earlier object keeps the pixel

    always_ff @(posedge clk) begin
        if (wr_ok)
            pix[bank][buf_addr] <= buf_pix;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            occ       <= '0;
            bank      <= 1'b0;
            video_pix <= PIX_EMPTY;
        end else begin
            if (wr_ok)
                occ[bank][buf_addr] <= 1'b1;
            occ[vbank][video_hpos] <= 1'b0;          // clear as it is read
            video_pix <= occ[vbank][video_hpos] ? pix[vbank][video_hpos] : PIX_EMPTY;
            if (line_start)
                bank <= ~bank;                       // swap draw and video banks
        end
    end

endmodule

/* obj_line_draw.sv */
`timescale 1ns/1ns
/* fetches one 16 pixel tile row and writes it to the line buffer
   rom_data must be valid exactly one cycle after rom_cs
   job takes 18 cycles from draw_req to draw_idle high again */
module obj_line_draw import obj_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        draw_req,
    input  obj_draw_t   draw_job,
    output logic        draw_idle,
    output logic        rom_cs,
    output logic [19:0] rom_addr,
    input  logic [63:0] rom_data,
    output logic        buf_we,
    output logic [8:0]  buf_addr,
    output obj_pix_t    buf_pix
);
    draw_state_e state;
    obj_draw_t   job_q;                     // job held for its whole run
    logic [63:0] row_q;                     // rom row, kept after first pixel
    logic [63:0] row;
    logic [3:0]  cnt;                       // pixel counter in screen order
    logic [3:0]  sel;                       // rom pixel for this screen pixel
    logic [3:0]  idx;

    assign draw_idle = (state == DR_IDLE);
    assign rom_cs    = (state == DR_FETCH);
    assign rom_addr  = {job_q.code, job_q.vsub};
    assign row       = (cnt == 4'd0) ? rom_data : row_q;   // rom only valid on pixel 0
    assign sel       = job_q.hflip ? 4'd15 - cnt : cnt;
    assign idx       = row[{sel, 2'b00} +: 4];
    assign buf_we    = (state == DR_PIXELS) && (idx != IDX_TRANSP);
    assign buf_addr  = job_q.hpos + {5'd0, cnt};          // wraps modulo 512
    assign buf_pix   = '{pal: job_q.pal, idx: idx};

    always_ff @(posedge clk) begin
        if (draw_req && draw_idle)
            job_q <= draw_job;
        if (state == DR_PIXELS && cnt == 4'd0)
            row_q <= rom_data;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= DR_IDLE;
            cnt   <= 4'd0;
        end else begin
            case (state)
                DR_IDLE: begin
                    if (draw_req)
                        state <= DR_FETCH;
                end
                DR_FETCH: begin
                    state <= DR_PIXELS;           // rom answers on next edge
                    cnt   <= 4'd0;
                end
                DR_PIXELS: begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'd15)
                        state <= DR_IDLE;         // 16th pixel out
                end
                default: state <= DR_IDLE;
            endcase
        end
    end

endmodule

/* obj_line_scan.sv */
`timescale 1ns/1ns
/* walks the object table on each line_start and issues tile jobs
   an entry with end_mark set is a terminator and is not drawn
   a new line_start aborts the walk in progress */
module obj_line_scan import obj_pkg::*; #(
    parameter int OBJ_AW = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flip,
    input  logic              line_start,
    input  logic [8:0]        vrender,
    output logic              rd_req,
    output logic [OBJ_AW-1:0] rd_addr,
    input  obj_entry_t        rd_entry,
    input  logic              rd_valid,
    output logic              draw_req,
    output obj_draw_t         draw_job,
    input  logic              draw_idle,
    output logic              scan_busy
);
    scan_state_e state;
    obj_entry_t  ent;                       // entry under test
    logic [8:0]  line_q;                    // render line, flip applied
    logic [3:0]  n;                         // tile column being issued
    logic [3:0]  npos;                      // screen column of tile n
    logic [8:0]  hpos;
    logic        rd_sent;                   // request for this entry is out
    logic        rd_out;                    // some read still unanswered
    logic        take;
    logic        issue;
    logic        inzone;
    logic [3:0]  vsub;
    logic [15:0] code_mn;

    obj_tile_match u_match (
        .clk     (clk),
        .entry   (ent),
        .line    (line_q),
        .n       (n),
        .inzone  (inzone),
        .vsub    (vsub),
        .code_mn (code_mn)
    );

    assign rd_req = (state == SC_READ) && !rd_sent && !rd_out;  // one read in flight
    assign take   = (state == SC_READ) && rd_sent && rd_valid;
    assign issue  = (state == SC_ISSUE) && inzone && draw_idle;
    assign npos   = ent.hflip ? ent.tile_w - n : n;    // reversed columns under hflip
    assign hpos   = ent.x + {1'b0, npos, 4'd0};        // wraps modulo 512

    always_ff @(posedge clk) begin
        if (line_start)
            line_q <= {vrender[8], vrender[7:0] ^ {8{flip}}};
        if (take)
            ent <= rd_entry;
        if (issue) begin
            draw_job.code  <= code_mn;
            draw_job.vsub  <= vsub;
            draw_job.hflip <= ent.hflip;
            draw_job.pal   <= ent.pal;
            draw_job.hpos  <= hpos;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= SC_IDLE;
            rd_addr   <= '0;
            rd_sent   <= 1'b0;
            rd_out    <= 1'b0;
            n         <= 4'd0;
            draw_req  <= 1'b0;
            scan_busy <= 1'b0;
        end else begin
            rd_out   <= (rd_req || rd_out) && !rd_valid;  // also tracks aborted reads
            draw_req <= 1'b0;                              // pulse only
            if (rd_req)
                rd_sent <= 1'b1;
            case (state)
                SC_READ: begin
                    if (take) begin
                        if (rd_entry.end_mark) begin
                            state     <= SC_IDLE;          // terminator, walk done
                            scan_busy <= 1'b0;
                        end else begin
                            state <= SC_MATCH;
                        end
                    end
                end
                SC_MATCH: state <= SC_ISSUE;               // matcher result lands next
                SC_ISSUE: begin
                    if (!inzone) begin
                        state <= SC_NEXT;                  // not on this line
                    end else if (draw_idle) begin
                        draw_req <= 1'b1;
                        if (n == ent.tile_w) begin
                            state <= SC_NEXT;
                        end else begin
                            n     <= n + 4'd1;
                            state <= SC_MATCH;             // new code_mn for next column
                        end
                    end
                end
                SC_NEXT: begin
                    n       <= 4'd0;
                    rd_sent <= 1'b0;
                    if (rd_addr == {OBJ_AW{1'b1}}) begin
                        state     <= SC_IDLE;              // ran off the table end
                        scan_busy <= 1'b0;
                    end else begin
                        rd_addr <= rd_addr + 1'b1;
                        state   <= SC_READ;
                    end
                end
                default: state <= SC_IDLE;
            endcase
            if (line_start) begin                          // overrides the case above
                state     <= SC_READ;
                rd_addr   <= '0;
                rd_sent   <= 1'b0;
                n         <= 4'd0;
                draw_req  <= 1'b0;
                scan_busy <= 1'b1;
            end
        end
    end

endmodule

/* obj_pkg.sv */
/* shared types for the object line engine
   entry fields follow host table layout, msb first
   tile sizes are in 16 pixel units, stored minus one */
package obj_pkg;

    localparam int OBJ_AW = 8;              // default table address width

    typedef struct packed {
        logic        end_mark;              // terminator, scan stops here
        logic [8:0]  y;                     // top row
        logic [8:0]  x;                     // left column
        logic [15:0] code;                  // first tile code
        logic [3:0]  tile_w;                // width in tiles - 1
        logic [3:0]  tile_h;                // height in tiles - 1
        logic        hflip;
        logic        vflip;
        logic [4:0]  pal;
        logic [1:0]  pad;                   // spare
    } obj_entry_t;

    typedef struct packed {
        logic [15:0] code;                  // tile code for this column
        logic [3:0]  vsub;                  // row in tile, flip applied
        logic        hflip;
        logic [4:0]  pal;
        logic [8:0]  hpos;                  // left pixel on screen
    } obj_draw_t;

    typedef struct packed {
        logic [4:0]  pal;
        logic [3:0]  idx;
    } obj_pix_t;

    localparam obj_pix_t   PIX_EMPTY  = 9'h1ff;  // nothing drawn here
    localparam logic [3:0] IDX_TRANSP = 4'd15;   // rom index never drawn

    typedef enum logic [2:0] {SC_IDLE, SC_READ, SC_MATCH, SC_ISSUE, SC_NEXT} scan_state_e;

    typedef enum logic [1:0] {DR_IDLE, DR_FETCH, DR_PIXELS} draw_state_e;

endpackage

/* obj_table_mem.sv */
`timescale 1ns/1ns
/* object table, one port shared by host writes and scanner reads
   host write always wins; a blocked read is held and served later
   requester must not send a new rd_req before rd_valid */
module obj_table_mem import obj_pkg::*; #(
    parameter int OBJ_AW = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              host_we,
    input  logic [OBJ_AW-1:0] host_addr,
    input  obj_entry_t        host_entry,
    input  logic              rd_req,
    input  logic [OBJ_AW-1:0] rd_addr,
    output obj_entry_t        rd_entry,
    output logic              rd_valid
);
    localparam int DEPTH = 1 << OBJ_AW;

    obj_entry_t        mem [DEPTH];         // table storage
    logic              pend;                // read waiting for a free port
    logic [OBJ_AW-1:0] pend_addr;
    logic              serve;
    logic [OBJ_AW-1:0] srv_addr;

    assign serve    = (rd_req || pend) && !host_we;  // host takes the port first
    assign srv_addr = pend ? pend_addr : rd_addr;    // held address has priority

    always_ff @(posedge clk) begin
        if (host_we) mem[host_addr] <= host_entry;
        if (serve) rd_entry <= mem[srv_addr];        // read sees any earlier write
        if (rd_req) pend_addr <= rd_addr;            // keep in case host blocks us
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pend     <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= serve;                       // data is out one edge later
            if (rd_req && host_we)
                pend <= 1'b1;                        // blocked, retry next free cycle
            else if (serve)
                pend <= 1'b0;
        end
    end

endmodule

/* obj_tile_match.sv */
`timescale 1ns/1ns
/* row test of one object against the render line
   all outputs registered, valid one cycle after the inputs
   code_mn assumes tiles laid out 16 codes per tile row */
module obj_tile_match import obj_pkg::*; (
    input  logic        clk,
    input  obj_entry_t  entry,
    input  logic [8:0]  line,
    input  logic [3:0]  n,
    output logic        inzone,
    output logic [3:0]  vsub,
    output logic [15:0] code_mn
);
    logic [8:0] row;                        // line relative to object top
    logic       hit;
    logic [3:0] m_raw;
    logic [3:0] m;

    assign row   = line - entry.y;          // wraps modulo 512
    assign hit   = row[8:4] <= {1'b0, entry.tile_h};  // below 16*(tile_h+1)
    assign m_raw = row[7:4];                // row[8] is zero whenever hit
    assign m     = entry.vflip ? entry.tile_h - m_raw : m_raw;

    always_ff @(posedge clk) begin
        inzone  <= hit;
        vsub    <= row[3:0] ^ {4{entry.vflip}};  // flip inside the tile
        code_mn <= entry.code + {12'd0, n} + {8'd0, m, 4'd0};
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the object engine testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_obj_engine; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_obj_engine +verilator+error+limit+100)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if grep -q "STATUS: PASS" <<< "$out"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* sources.f */
obj_pkg.sv
obj_table_mem.sv
obj_tile_match.sv
obj_line_scan.sv
obj_line_draw.sv
obj_line_buf.sv
obj_engine_top.sv
obj_engine_asserts.sv
tb_obj_engine.sv

/* tb_obj_engine.sv */
`timescale 1ns/1ns
/* directed testbench for obj_engine_top, rom model answers one cycle after rom_cs
   each test renders one line, swaps banks and reads all 512 pixels back
   video_hpos rests at 0 between readouts, so pixel 0 is read first */
module tb_obj_engine import obj_pkg::*; ();
    localparam int N_TESTS     = 6;
    localparam int TEST_CYCLES = 3000;            // per test, readout alone is 512
    localparam logic [31:0] SEED = 32'hd1c2_bf25;

    logic        clk, rst, flip, line_start, host_we, rom_cs, scan_busy;
    logic [8:0]  vrender, video_hpos;
    logic [7:0]  host_addr;
    obj_entry_t  host_entry;
    logic [19:0] rom_addr;
    logic [63:0] rom_data;
    obj_pix_t    video_pix;

    obj_entry_t  tbl [256];                       // model copy of the table
    obj_pix_t    exp_pix [512];
    logic        exp_occ [512];
    logic [31:0] rng;

    obj_engine_top #(.OBJ_AW(8)) DUT (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = lcg_step(rng);
        return rng;
    endfunction

    // tile row for a rom address, roughly 30% of pixels transparent
    function automatic logic [63:0] rom_row(input logic [19:0] addr);
        logic [31:0] s;
        logic [63:0] r;
        s = SEED ^ ({12'd0, addr} * 32'h9e37_79b9);
        for (int k = 0; k < 16; k++) begin
            s = lcg_step(s);
            r[4*k +: 4] = (s[27:26] == 2'b00) ? IDX_TRANSP : s[31:28];
        end
        return r;
    endfunction

    always @(posedge clk) begin
        if (rom_cs)
            rom_data <= rom_row(rom_addr);        // one cycle latency
    end

    function automatic obj_entry_t make_obj(input logic [8:0] x, input logic [8:0] y,
            input logic [15:0] code, input logic [3:0] w, input logic [3:0] h,
            input logic hf, input logic vf, input logic [4:0] pal);
        return '{end_mark: 1'b0, y: y, x: x, code: code, tile_w: w, tile_h: h,
                 hflip: hf, vflip: vf, pal: pal, pad: 2'b00};
    endfunction

    function automatic logic [8:0] render_line(input logic [8:0] v, input logic f);
        return f ? {v[8], ~v[7:0]} : v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "wrong value from DUT");
        end
    endtask

    // expected line, table order gives priority
    task automatic build_expected(input logic [8:0] line);
        obj_entry_t  e;
        logic [8:0]  row, hp, a;
        logic [3:0]  m, vs, npos, idx;
        logic [15:0] code;
        logic [63:0] r;
        for (int p = 0; p < 512; p++) begin
            exp_pix[p] = PIX_EMPTY;
            exp_occ[p] = 1'b0;
        end
        for (int i = 0; i < 256; i++) begin
            e = tbl[i];
            if (e.end_mark)
                break;
            row = line - e.y;                     // modulo 512
            if (int'(row) < 16 * (int'(e.tile_h) + 1)) begin
                m  = row[7:4];
                vs = row[3:0];
                if (e.vflip) begin
                    m  = e.tile_h - m;
                    vs = 4'd15 - vs;
                end
                for (int n = 0; n <= int'(e.tile_w); n++) begin
                    code = e.code + 16'(n) + {8'd0, m, 4'd0};
                    npos = e.hflip ? e.tile_w - 4'(n) : 4'(n);
                    hp   = e.x + {1'b0, npos, 4'd0};
                    r    = rom_row({code, vs});
                    for (int k = 0; k < 16; k++) begin
                        idx = e.hflip ? r[4*(15-k) +: 4] : r[4*k +: 4];
                        a   = hp + 9'(k);
                        if (idx != IDX_TRANSP && !exp_occ[a]) begin
                            exp_pix[a] = '{pal: e.pal, idx: idx};
                            exp_occ[a] = 1'b1;
                        end
                    end
                end
            end
        end
    endtask

    task automatic write_entry(input int addr, input obj_entry_t e);
        @(posedge clk);
        host_we    <= 1'b1;
        host_addr  <= 8'(addr);
        host_entry <= e;
        @(posedge clk);
        host_we <= 1'b0;
        tbl[addr] = e;
    endtask

    task automatic write_end(input int addr);
        obj_entry_t e;
        e = '0;
        e.end_mark = 1'b1;
        write_entry(addr, e);
    endtask

    task automatic pulse_line(input logic [8:0] v);
        @(posedge clk);
        line_start <= 1'b1;
        vrender    <= v;
        @(posedge clk);
        line_start <= 1'b0;
    endtask

    task automatic wait_scan();
        @(negedge clk);
        while (scan_busy)
            @(negedge clk);
        repeat (20) @(posedge clk);               // last job still drawing
    endtask

    // location a is read at the edge, pix is out by the negedge
    task automatic read_line(input string name);
        for (int a = 0; a < 512; a++) begin
            @(posedge clk);
            video_hpos <= 9'(a + 1);              // back to 0 after the last one
            @(negedge clk);
            check_val($sformatf("%s hpos %0d", name, a), 32'(exp_pix[a]), 32'(video_pix));
        end
    endtask

    task automatic finish_line(input string name, input logic [8:0] v);
        wait_scan();
        pulse_line(v);                            // swap banks
        read_line(name);
        wait_scan();                              // walk started by the swap
    endtask

    task automatic run_line(input string name, input logic [8:0] v);
        build_expected(render_line(v, 1'b0));
        pulse_line(v);
        finish_line(name, v);
    endtask

    task automatic test_single();
        write_entry(0, make_obj(9'd100, 9'd50, 16'h0040, 4'd0, 4'd0, 1'b0, 1'b0, 5'd3));
        write_entry(1, make_obj(9'd505, 9'd48, 16'h0101, 4'd0, 4'd0, 1'b0, 1'b0, 5'd17));
        write_end(2);
        run_line("single", 9'd55);
    endtask

    task automatic test_flip();
        write_entry(0, make_obj(9'd200, 9'd100, 16'h1230, 4'd2, 4'd1, 1'b1, 1'b1, 5'd9));
        write_end(1);
        run_line("hflip vflip", 9'd121);          // second tile row
    endtask

    task automatic test_overlap();
        write_entry(0, make_obj(9'd300, 9'd10, 16'h0200, 4'd0, 4'd0, 1'b0, 1'b0, 5'd1));
        write_entry(1, make_obj(9'd308, 9'd8, 16'h0300, 4'd1, 4'd0, 1'b0, 1'b0, 5'd2));
        write_end(2);
        run_line("overlap", 9'd12);
    endtask

    task automatic test_skip();
        obj_entry_t e;
        e = make_obj(9'd60, 9'd36, 16'h0500, 4'd0, 4'd0, 1'b0, 1'b0, 5'd6);
        e.end_mark = 1'b1;                        // in zone, still a terminator
        write_entry(0, make_obj(9'd20, 9'd200, 16'h0400, 4'd0, 4'd0, 1'b0, 1'b0, 5'd4));
        write_entry(1, make_obj(9'd50, 9'd36, 16'h0410, 4'd0, 4'd0, 1'b0, 1'b0, 5'd5));
        write_entry(2, e);
        write_entry(3, make_obj(9'd70, 9'd38, 16'h0420, 4'd0, 4'd0, 1'b0, 1'b0, 5'd7));
        run_line("zone and end mark", 9'd40);
    endtask

    task automatic test_host_storm();
        obj_entry_t e;
        for (int i = 0; i < 6; i++)
            write_entry(i, make_obj(9'(40 + 60 * i), 9'd200, 16'(16'h0600 + 16 * i),
                                    4'd0, 4'd0, 1'b0, 1'b0, 5'(i + 4)));
        write_end(6);
        flip <= 1'b1;
        build_expected(render_line(9'h032, 1'b1));  // line 205 only with flip
        pulse_line(9'h032);
        for (int k = 0; k < 40; k++) begin
            e = make_obj(9'(next_rand()), 9'd200, 16'(next_rand()), 4'd1, 4'd0,
                         1'b0, 1'b0, 5'(next_rand()));
            @(posedge clk);
            host_we    <= 1'b1;                   // every cycle, past the end mark
            host_addr  <= 8'(8 + k);
            host_entry <= e;
            tbl[8 + k] = e;
        end
        @(posedge clk);
        host_we <= 1'b0;
        finish_line("host storm", 9'h032);
        flip <= 1'b0;
    endtask

    task automatic test_clear();
        for (int p = 0; p < 512; p++)
            exp_pix[p] = PIX_EMPTY;
        read_line("clear on read");               // same bank again
    endtask

    initial begin
        rng        = SEED;
        rst        = 1'b1;
        flip       = 1'b0;
        line_start = 1'b0;
        vrender    = '0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_entry = '0;
        rom_data   = '0;
        video_hpos = '0;
        for (int i = 0; i < 256; i++)
            tbl[i] = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        test_single();
        test_flip();
        test_overlap();
        test_skip();
        test_host_storm();
        test_clear();
        if (DUT.u_asserts.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("handshake assertions failed %0d times", DUT.u_asserts.fail_count);
            $display("STATUS: FAIL");
            $fatal(1, "assertion failures");
        end
    end

    initial begin
        repeat (N_TESTS * TEST_CYCLES) @(posedge clk);
        $display("timeout, tests still running after %0d cycles", N_TESTS * TEST_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule
